// File: Makefile
TOP := tb_monitor
OBJ := obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) --Mdir $(OBJ) -f sim.f

run: compile
	./$(OBJ)/V$(TOP) +verilator+error+limit+100

clean:
	rm -rf $(OBJ)

// File: correlator_capture.sv
module correlator_capture import gps_pkg::*; (
   input  logic clk_16_8,
   input  logic i_arst_n,
   input  logic i_acc_valid,
   input  acc_t i_i_early,
   input  acc_t i_q_early,
   input  acc_t i_i_prompt,
   input  acc_t i_q_prompt,
   input  acc_t i_i_late,
   input  acc_t i_q_late,
   output acc_t o_i_early,
   output acc_t o_q_early,
   output acc_t o_i_prompt,
   output acc_t o_q_prompt,
   output acc_t o_i_late,
   output acc_t o_q_late
);

   // All six load together so the display never mixes two periods
   always_ff @(posedge clk_16_8 or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_i_early  <= '0;
         o_q_early  <= '0;
         o_i_prompt <= '0;
         o_q_prompt <= '0;
         o_i_late   <= '0;
         o_q_late   <= '0;
      end else if (i_acc_valid) begin
         o_i_early  <= i_i_early;   // Early arm
         o_q_early  <= i_q_early;
         o_i_prompt <= i_i_prompt;  // Prompt arm
         o_q_prompt <= i_q_prompt;
         o_i_late   <= i_i_late;    // Late arm
         o_q_late   <= i_q_late;
      end
   end

endmodule

// File: display_select.sv
module display_select import gps_pkg::*; (
   input  logic          clk_16_8,
   input  logic          i_arst_n,
   input  logic          i_sw_q_i,
   input  logic          i_sw_el_p,
   input  logic          i_sw_e_l,
   input  logic          i_sw_pkt,
   input  logic          i_sw_pkt_good,
   input  logic          i_sw_count,
   input  acc_t          i_i_early,
   input  acc_t          i_q_early,
   input  acc_t          i_i_prompt,
   input  acc_t          i_q_prompt,
   input  acc_t          i_i_late,
   input  acc_t          i_q_late,
   input  pkt_count_t    i_good_pkt_count,
   input  pkt_count_t    i_missed_count,
   input  sample_count_t i_sample_count,
   output ledr_t         o_ledr,
   output nibble_t       o_digit [NUM_DIGITS],
   output logic          o_blank [NUM_DIGITS]
);

   acc_t                            sel_value;
   ledr_t                           ledr_next;
   logic [NIBBLE_W*NUM_DIGITS-1:0]  digit_word;
   nibble_t                         digit_next [NUM_DIGITS];
   logic                            blank_next [NUM_DIGITS];

   // Correlation arm and component picked by the switches
   always_comb begin
      if (i_sw_el_p && i_sw_e_l) begin
         sel_value = i_sw_q_i ? i_q_early : i_i_early;
      end else if (i_sw_el_p) begin
         sel_value = i_sw_q_i ? i_q_late : i_i_late;
      end else begin
         sel_value = i_sw_q_i ? i_q_prompt : i_i_prompt;
      end
   end

   always_comb begin
      if (i_sw_pkt) begin
         ledr_next = i_sw_pkt_good ? ledr_t'(i_good_pkt_count) : ledr_t'(i_missed_count);
      end else begin
         ledr_next = sel_value[LEDR_W-1:0];          // Top bit of the value is dropped
      end
   end

   // Zero extension puts the top 3 correlation bits on digit 4
   assign digit_word = i_sw_count ? i_sample_count : (NIBBLE_W*NUM_DIGITS)'(sel_value);

   always_comb begin
      for (int k = 0; k < NUM_DIGITS; k++) begin
         digit_next[k] = digit_word[NIBBLE_W*k +: NIBBLE_W];
         blank_next[k] = !i_sw_count && (k >= CORR_DIGITS);
      end
   end

   always_ff @(posedge clk_16_8 or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_ledr <= '0;
         for (int k = 0; k < NUM_DIGITS; k++) begin
            o_digit[k] <= '0;
            o_blank[k] <= 1'b1;                      // Display dark in reset
         end
      end else begin
         o_ledr <= ledr_next;
         for (int k = 0; k < NUM_DIGITS; k++) begin
            o_digit[k] <= digit_next[k];
            o_blank[k] <= blank_next[k];
         end
      end
   end

endmodule

// File: gps_pkg.sv
package gps_pkg;

   localparam int ACC_W          = 19;   // Correlator accumulation width
   localparam int PKT_COUNT_W    = 9;    // Packet counters from the sample feed
   localparam int SAMPLE_COUNT_W = 32;
   localparam int LEDR_W         = 18;   // Red LED bank
   localparam int NIBBLE_W       = 4;
   localparam int SEG_W          = 7;    // Segments a to g
   localparam int DIV_W          = 4;    // Sample clock divider counter

   localparam int NUM_DIGITS     = 8;
   // Digits 4 to 0 carry a correlation value, the rest go dark
   localparam int CORR_DIGITS    = 5;

   typedef logic [ACC_W-1:0]          acc_t;
   typedef logic [PKT_COUNT_W-1:0]    pkt_count_t;
   typedef logic [SAMPLE_COUNT_W-1:0] sample_count_t;
   typedef logic [LEDR_W-1:0]         ledr_t;
   typedef logic [NIBBLE_W-1:0]       nibble_t;
   typedef logic [SEG_W-1:0]          segments_t;   // Bit 0 is a, bit 6 is g
   typedef logic [DIV_W-1:0]          div_count_t;

   // Toggle every 9 cycles of clk_16_8, slow clock period of 18
   localparam div_count_t SAMPLE_DIV_RELOAD = div_count_t'(8);

   // Segments light at 0
   localparam segments_t SEG_BLANK = '1;

endpackage

// File: monitor_asserts.sv
module monitor_asserts import gps_pkg::*; (
   input logic      clk_16_8,
   input logic      i_arst_n,
   input logic      i_sw_count,
   input logic      i_sw_pkt,
   input logic      i_sample_tick,
   input ledr_t     i_ledr,
   input segments_t i_hex5,
   input segments_t i_hex6,
   input segments_t i_hex7
);

   timeunit 1ns;
   timeprecision 1ps;

   int         assert_errors = 0;
   logic [4:0] since_tick;                  // Cycles since the last tick
   logic       tick_seen;

   always_ff @(posedge clk_16_8 or negedge i_arst_n) begin
      if (!i_arst_n) begin
         since_tick <= '0;
         tick_seen  <= 1'b0;
      end else if (i_sample_tick) begin
         since_tick <= '0;
         tick_seen  <= 1'b1;
      end else if (since_tick != '1) begin
         since_tick <= since_tick + 5'd1;   // Saturates
      end
   end

   tick_width: assert property (@(posedge clk_16_8) disable iff (!i_arst_n)
      i_sample_tick |=> !i_sample_tick)
      else begin
         $error("sample tick high on two consecutive cycles");
         assert_errors++;
      end

   // Next tick exactly 18 cycles after the previous one
   tick_spacing: assert property (@(posedge clk_16_8) disable iff (!i_arst_n)
      tick_seen |-> (i_sample_tick == (since_tick == 5'd17)))
      else begin
         $error("sample ticks are not 18 cycles apart");
         assert_errors++;
      end

   upper_digits_dark: assert property (@(posedge clk_16_8) disable iff (!i_arst_n)
      !i_sw_count |=> (i_hex5 == SEG_BLANK && i_hex6 == SEG_BLANK && i_hex7 == SEG_BLANK))
      else begin
         $error("digits 7 to 5 lit outside count mode");
         assert_errors++;
      end

   pkt_ledr_width: assert property (@(posedge clk_16_8) disable iff (!i_arst_n)
      i_sw_pkt |=> (i_ledr[LEDR_W-1:PKT_COUNT_W] == '0))
      else begin
         $error("upper LED bits set in packet mode");
         assert_errors++;
      end

endmodule

// File: monitor_top.sv
module monitor_top import gps_pkg::*; (
   input  logic       clk_16_8,
   input  logic       i_arst_n,
   input  logic       i_sample_valid,
   input  logic       i_acc_valid,
   input  acc_t       i_i_early,
   input  acc_t       i_q_early,
   input  acc_t       i_i_prompt,
   input  acc_t       i_q_prompt,
   input  acc_t       i_i_late,
   input  acc_t       i_q_late,
   input  pkt_count_t i_good_pkt_count,
   input  pkt_count_t i_missed_count,
   input  logic       i_sw_q_i,
   input  logic       i_sw_el_p,
   input  logic       i_sw_e_l,
   input  logic       i_sw_pkt,
   input  logic       i_sw_pkt_good,
   input  logic       i_sw_count,
   output logic       o_clk_sample,
   output logic       o_sample_tick,
   output logic       o_sample_valid_led,
   output ledr_t      o_ledr,
   output segments_t  o_hex0,
   output segments_t  o_hex1,
   output segments_t  o_hex2,
   output segments_t  o_hex3,
   output segments_t  o_hex4,
   output segments_t  o_hex5,
   output segments_t  o_hex6,
   output segments_t  o_hex7
);

   sample_count_t sample_count;
   acc_t          hold_i_early, hold_q_early;
   acc_t          hold_i_prompt, hold_q_prompt;
   acc_t          hold_i_late, hold_q_late;
   nibble_t       digit [NUM_DIGITS];
   logic          blank [NUM_DIGITS];
   segments_t     hex   [NUM_DIGITS];

   // Feed status LED
   always_ff @(posedge clk_16_8 or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_sample_valid_led <= 1'b0;
      end else begin
         o_sample_valid_led <= i_sample_valid;
      end
   end

   sample_timebase u_timebase (
      .clk_16_8       (clk_16_8),
      .i_arst_n       (i_arst_n),
      .i_sample_valid (i_sample_valid),
      .o_clk_sample   (o_clk_sample),
      .o_sample_tick  (o_sample_tick),
      .o_sample_count (sample_count)
   );

   correlator_capture u_capture (
      .clk_16_8   (clk_16_8),
      .i_arst_n   (i_arst_n),
      .i_acc_valid(i_acc_valid),
      .i_i_early  (i_i_early),
      .i_q_early  (i_q_early),
      .i_i_prompt (i_i_prompt),
      .i_q_prompt (i_q_prompt),
      .i_i_late   (i_i_late),
      .i_q_late   (i_q_late),
      .o_i_early  (hold_i_early),
      .o_q_early  (hold_q_early),
      .o_i_prompt (hold_i_prompt),
      .o_q_prompt (hold_q_prompt),
      .o_i_late   (hold_i_late),
      .o_q_late   (hold_q_late)
   );

   display_select u_select (
      .clk_16_8         (clk_16_8),
      .i_arst_n         (i_arst_n),
      .i_sw_q_i         (i_sw_q_i),
      .i_sw_el_p        (i_sw_el_p),
      .i_sw_e_l         (i_sw_e_l),
      .i_sw_pkt         (i_sw_pkt),
      .i_sw_pkt_good    (i_sw_pkt_good),
      .i_sw_count       (i_sw_count),
      .i_i_early        (hold_i_early),
      .i_q_early        (hold_q_early),
      .i_i_prompt       (hold_i_prompt),
      .i_q_prompt       (hold_q_prompt),
      .i_i_late         (hold_i_late),
      .i_q_late         (hold_q_late),
      .i_good_pkt_count (i_good_pkt_count),
      .i_missed_count   (i_missed_count),
      .i_sample_count   (sample_count),
      .o_ledr           (o_ledr),
      .o_digit          (digit),
      .o_blank          (blank)
   );

   for (genvar d = 0; d < NUM_DIGITS; d++) begin : g_digit
      seven_seg_encoder u_enc (
         .i_nibble   (digit[d]),
         .i_blank    (blank[d]),
         .o_segments (hex[d])
      );
   end

   assign o_hex0 = hex[0];   // Rightmost digit
   assign o_hex1 = hex[1];
   assign o_hex2 = hex[2];
   assign o_hex3 = hex[3];
   assign o_hex4 = hex[4];
   assign o_hex5 = hex[5];
   assign o_hex6 = hex[6];
   assign o_hex7 = hex[7];

endmodule

// File: sample_timebase.sv
module sample_timebase import gps_pkg::*; (
   input  logic          clk_16_8,
   input  logic          i_arst_n,
   input  logic          i_sample_valid,
   output logic          o_clk_sample,
   output logic          o_sample_tick,
   output sample_count_t o_sample_count
);

   div_count_t div_cnt;
   logic       div_wrap;
   logic       clk_rise;

   assign div_wrap = (div_cnt == '0);
   assign clk_rise = div_wrap && !o_clk_sample;   // Slow clock about to go high

   always_ff @(posedge clk_16_8 or negedge i_arst_n) begin
      if (!i_arst_n) begin
         div_cnt        <= '0;                    // First toggle right after reset
         o_clk_sample   <= 1'b0;
         o_sample_tick  <= 1'b0;
         o_sample_count <= '0;
      end else begin
         if (div_wrap) begin
            div_cnt      <= SAMPLE_DIV_RELOAD;
            o_clk_sample <= !o_clk_sample;
         end else begin
            div_cnt <= div_cnt - div_count_t'(1);
         end

         o_sample_tick <= clk_rise;               // High with the new high phase

         // Only samples the feed marked as good are counted
         if (clk_rise && i_sample_valid) begin
            o_sample_count <= o_sample_count + sample_count_t'(1);
         end
      end
   end

endmodule

// File: seven_seg_encoder.sv
module seven_seg_encoder import gps_pkg::*; (
   input  nibble_t   i_nibble,
   input  logic      i_blank,
   output segments_t o_segments
);

   segments_t glyph;

   // Patterns written as gfedcba, a lit segment is 0
   always_comb begin
      case (i_nibble)
         4'h0:    glyph = 7'b1000000;
         4'h1:    glyph = 7'b1111001;
         4'h2:    glyph = 7'b0100100;
         4'h3:    glyph = 7'b0110000;
         4'h4:    glyph = 7'b0011001;
         4'h5:    glyph = 7'b0010010;
         4'h6:    glyph = 7'b0000010;
         4'h7:    glyph = 7'b1111000;
         4'h8:    glyph = 7'b0000000;
         4'h9:    glyph = 7'b0010000;
         4'ha:    glyph = 7'b0001000;
         4'hb:    glyph = 7'b0000011;   // Lower case b
         4'hc:    glyph = 7'b1000110;
         4'hd:    glyph = 7'b0100001;   // Lower case d
         4'he:    glyph = 7'b0000110;
         default: glyph = 7'b0001110;   // F
      endcase
   end

   assign o_segments = i_blank ? SEG_BLANK : glyph;

endmodule

// File: sim.f
gps_pkg.sv
sample_timebase.sv
correlator_capture.sv
display_select.sv
seven_seg_encoder.sv
monitor_top.sv
monitor_asserts.sv
tb_monitor.sv

// File: tb_monitor.sv
module tb_monitor import gps_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_CYCLES       = 2000;
   localparam int TIMEOUT_CYCLES   = 2 * NUM_CYCLES;
   localparam int RESET_CYCLES     = 10;
   localparam int HALF_PERIOD      = int'(SAMPLE_DIV_RELOAD) + 1;   // Slow clock phase length
   localparam int FIRST_DARK_DIGIT = 5;

   logic       clk_16_8 = 1'b0;
   logic       i_arst_n = 1'b1;
   logic       i_sample_valid;
   logic       i_acc_valid;
   acc_t       acc_in [6];          // I/Q early, prompt, late
   pkt_count_t good_pkt;
   pkt_count_t missed;
   logic       sw_q_i, sw_el_p, sw_e_l, sw_pkt, sw_pkt_good, sw_count;

   logic          o_clk_sample;
   logic          o_sample_tick;
   logic          o_sample_valid_led;
   ledr_t         o_ledr;
   segments_t     hex [NUM_DIGITS];

   // Reference model state
   acc_t          m_held [6];
   sample_count_t m_count;
   logic          exp_clk, exp_tick, exp_valid_led;
   ledr_t         exp_ledr;
   segments_t     exp_hex [NUM_DIGITS];
   logic [7:0]    combo_seen;       // Switch combinations seen in correlation mode
   int            hold_left;
   int            cycle_count = 0;

   always #10 clk_16_8 = ~clk_16_8;

   monitor_top dut (
      .clk_16_8           (clk_16_8),
      .i_arst_n           (i_arst_n),
      .i_sample_valid     (i_sample_valid),
      .i_acc_valid        (i_acc_valid),
      .i_i_early          (acc_in[0]),
      .i_q_early          (acc_in[1]),
      .i_i_prompt         (acc_in[2]),
      .i_q_prompt         (acc_in[3]),
      .i_i_late           (acc_in[4]),
      .i_q_late           (acc_in[5]),
      .i_good_pkt_count   (good_pkt),
      .i_missed_count     (missed),
      .i_sw_q_i           (sw_q_i),
      .i_sw_el_p          (sw_el_p),
      .i_sw_e_l           (sw_e_l),
      .i_sw_pkt           (sw_pkt),
      .i_sw_pkt_good      (sw_pkt_good),
      .i_sw_count         (sw_count),
      .o_clk_sample       (o_clk_sample),
      .o_sample_tick      (o_sample_tick),
      .o_sample_valid_led (o_sample_valid_led),
      .o_ledr             (o_ledr),
      .o_hex0             (hex[0]),
      .o_hex1             (hex[1]),
      .o_hex2             (hex[2]),
      .o_hex3             (hex[3]),
      .o_hex4             (hex[4]),
      .o_hex5             (hex[5]),
      .o_hex6             (hex[6]),
      .o_hex7             (hex[7])
   );

   bind monitor_top monitor_asserts u_asserts (
      .clk_16_8      (clk_16_8),
      .i_arst_n      (i_arst_n),
      .i_sw_count    (i_sw_count),
      .i_sw_pkt      (i_sw_pkt),
      .i_sample_tick (o_sample_tick),
      .i_ledr        (o_ledr),
      .i_hex5        (o_hex5),
      .i_hex6        (o_hex6),
      .i_hex7        (o_hex7)
   );

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("Some tests failed");
      $fatal(1, "Stopping at the first failure");
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         stop_on_error($sformatf("FAIL at %0d ns: %s is %b, expected %b", $time, what, got, exp));
      end
   endtask

   task automatic check_ledr(input ledr_t got, input ledr_t exp, input string what);
      if (got !== exp) begin
         stop_on_error($sformatf("FAIL at %0d ns: %s is %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic check_segments(input segments_t got, input segments_t exp, input string what);
      if (got !== exp) begin
         stop_on_error($sformatf("FAIL at %0d ns: %s is %b, expected %b", $time, what, got, exp));
      end
   endtask

   task automatic check_count(input sample_count_t got, input sample_count_t exp,
                              input string what);
      if (got !== exp) begin
         stop_on_error($sformatf("FAIL at %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
      end
   endtask

   // Table lists the lit segments as gfedcba
   function automatic segments_t glyph_of(input nibble_t v);
      segments_t lit;
      case (v)
         4'h0:    lit = 7'h3f;
         4'h1:    lit = 7'h06;
         4'h2:    lit = 7'h5b;
         4'h3:    lit = 7'h4f;
         4'h4:    lit = 7'h66;
         4'h5:    lit = 7'h6d;
         4'h6:    lit = 7'h7d;
         4'h7:    lit = 7'h07;
         4'h8:    lit = 7'h7f;
         4'h9:    lit = 7'h6f;
         4'ha:    lit = 7'h77;
         4'hb:    lit = 7'h7c;
         4'hc:    lit = 7'h39;
         4'hd:    lit = 7'h5e;
         4'he:    lit = 7'h79;
         default: lit = 7'h71;
      endcase
      return ~lit;                          // Active low
   endfunction

   task automatic reset_model();
      m_count       = '0;
      exp_clk       = 1'b0;
      exp_tick      = 1'b0;
      exp_valid_led = 1'b0;
      exp_ledr      = '0;
      for (int a = 0; a < 6; a++) begin
         m_held[a] = '0;
      end
      for (int k = 0; k < NUM_DIGITS; k++) begin
         exp_hex[k] = SEG_BLANK;
      end
   endtask

   // Edge n counts from 1 after reset release
   task automatic step_model(input int n);
      int            phase;
      int            base;
      acc_t          sel;
      sample_count_t word;
      phase = (n - 1) % (2 * HALF_PERIOD);
      base  = (sw_el_p && sw_e_l) ? 0 : (sw_el_p ? 4 : 2);
      sel   = m_held[base + int'(sw_q_i)];   // Display loads the values held before this edge
      if (sw_pkt) begin
         exp_ledr = sw_pkt_good ? ledr_t'(good_pkt) : ledr_t'(missed);
      end else begin
         exp_ledr = sel[LEDR_W-1:0];
         combo_seen[{sw_q_i, sw_el_p, sw_e_l}] = 1'b1;
      end
      word = sw_count ? m_count : sample_count_t'(sel);
      for (int k = 0; k < NUM_DIGITS; k++) begin
         exp_hex[k] = (!sw_count && k >= FIRST_DARK_DIGIT) ? SEG_BLANK : glyph_of(word[4*k +: 4]);
      end
      if (i_acc_valid) begin
         for (int a = 0; a < 6; a++) begin
            m_held[a] = acc_in[a];
         end
      end
      exp_clk       = (phase < HALF_PERIOD);
      exp_tick      = (phase == 0);
      exp_valid_led = i_sample_valid;
      if (phase == 0 && i_sample_valid) begin
         m_count = m_count + sample_count_t'(1);
      end
   endtask

   task automatic check_outputs();
      check_bit(o_clk_sample, exp_clk, "o_clk_sample");
      check_bit(o_sample_tick, exp_tick, "o_sample_tick");
      check_bit(o_sample_valid_led, exp_valid_led, "o_sample_valid_led");
      check_ledr(o_ledr, exp_ledr, "o_ledr");
      check_count(dut.sample_count, m_count, "sample count");
      for (int k = 0; k < NUM_DIGITS; k++) begin
         check_segments(hex[k], exp_hex[k], $sformatf("o_hex%0d", k));
      end
   endtask

   task automatic drive_inputs();
      i_sample_valid = ($urandom % 4) != 0;
      i_acc_valid    = ($urandom % 4) == 0;   // About one cycle in four
      for (int a = 0; a < 6; a++) begin
         acc_in[a] = acc_t'($urandom);
      end
      if (hold_left == 0) begin
         sw_q_i      = 1'($urandom);
         sw_el_p     = 1'($urandom);
         sw_e_l      = 1'($urandom);
         sw_pkt      = ($urandom % 4) == 0;
         sw_pkt_good = 1'($urandom);
         sw_count    = ($urandom % 4) == 0;
         good_pkt    = pkt_count_t'($urandom);
         missed      = pkt_count_t'($urandom);
         hold_left   = int'($urandom % 4) + 1;
      end else begin
         hold_left = hold_left - 1;
      end
   endtask

   always @(posedge clk_16_8) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         stop_on_error($sformatf("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES));
      end
   end

   initial begin
      void'($urandom(32'hcd7a));
      i_arst_n       = 1'b0;
      i_sample_valid = 1'b1;                // Busy inputs that reset has to mask
      i_acc_valid    = 1'b1;
      for (int a = 0; a < 6; a++) begin
         acc_in[a] = '1;
      end
      good_pkt    = '1;
      missed      = '1;
      sw_q_i      = 1'b0;
      sw_el_p     = 1'b0;
      sw_e_l      = 1'b0;
      sw_pkt      = 1'b1;
      sw_pkt_good = 1'b1;
      sw_count    = 1'b1;
      hold_left   = 0;
      combo_seen  = '0;
      reset_model();
      repeat (RESET_CYCLES) begin
         @(posedge clk_16_8);
         #1;
         check_outputs();                   // Dark display and idle timebase
      end
      #1;
      i_arst_n = 1'b1;
      drive_inputs();
      for (int n = 1; n <= NUM_CYCLES; n++) begin
         @(posedge clk_16_8);
         step_model(n);
         #1;
         check_outputs();
         #1;
         drive_inputs();
      end
      if (dut.u_asserts.assert_errors != 0) begin
         stop_on_error($sformatf("%0d assertion failures were reported",
                                 dut.u_asserts.assert_errors));
      end else if (combo_seen != 8'hff) begin
         stop_on_error("Not every correlation switch combination was exercised");
      end else begin
         $display("All tests passed");
         $finish;
      end
   end

endmodule
